// ==== Makefile ====
# Verilator build and run of the fetch unit testbench

VERILATOR ?= verilator
TOP       ?= fetch_unit_tb
FILELIST  ?= fetch_unit.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

# build, run, then decide on the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '** PASS **' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== fetch_control.sv ====
// fetch control with the single-instruction ready flag, fetch decision and redirect

`timescale 1ns/1ns

module fetch_control (
  input  logic              clock,
  input  logic              reset,
  input  logic              ret_valid_inst,    // retire pulse, reopens fetch
  input  logic              ret_take_branch,   // retired branch was taken
  input  logic              ret_branch_valid,  // retired inst really is a branch
  input  fetch_pkg::addr_t  ret_target_pc,     // target of the retired branch
  input  logic              imem_valid,        // memory answer valid this cycle
  input  logic              queue_full,        // no room for another packet
  pc_ctrl_if.control        pc,
  output logic              push               // write fetched packet into queue
);
  import fetch_pkg::*;

  ////////////////////
  // internal state
  ////////////////////

  logic ready;        // one instruction may be fetched
  logic redirect;     // taken branch at retire
  logic fetch_valid;  // a fetch happens on the coming edge

  ////////////////////
  // redirect
  ////////////////////

  // all three retire strobes must agree before the pc is steered away
  assign redirect = ret_valid_inst & ret_take_branch & ret_branch_valid;

  assign pc.redirect  = redirect;
  assign pc.target_pc = ret_target_pc;  // only looked at while redirect is high

  ////////////////////
  // fetch decision
  ////////////////////

  // the redirect blocks fetch so the stale pc is never queued
  assign fetch_valid = ready & imem_valid & ~queue_full & ~redirect;

  // one decision feeds both the pc step and the queue write
  assign pc.advance = fetch_valid;
  assign push       = fetch_valid;

  ////////////////////
  // ready flag
  ////////////////////

  // set after reset so the first instruction goes out without a retire
  // a retire reopens fetch, a fetch closes it until the next retire
  // while the queue is full the flag simply stays set
  always_ff @(posedge clock) begin
    if (reset) begin
      ready <= 1'b1;
    end else if (ret_valid_inst) begin
      ready <= 1'b1;           // retire always wins
    end else if (fetch_valid) begin
      ready <= 1'b0;           // one instruction now in flight
    end
  end

endmodule

// ==== fetch_pkg.sv ====
// fetch package with the widths and packet type shared by the fetch subsystem

package fetch_pkg;

  ////////////////////
  // widths
  ////////////////////

  localparam int addr_w = 64;  // pc and memory byte address
  localparam int inst_w = 32;  // one instruction
  localparam int line_w = 64;  // one instruction memory line, two instructions

  ////////////////////
  // types
  ////////////////////

  typedef logic [addr_w-1:0] addr_t;  // pc or byte address
  typedef logic [inst_w-1:0] inst_t;  // raw instruction word

  // one fetched instruction on its way to dispatch
  typedef struct packed {
    addr_t npc;   // fetched pc + 4
    inst_t inst;  // instruction taken from the selected line half
  } fetch_packet_t;

endpackage

// ==== fetch_queue.sv ====
// circular FIFO of fetch packets toward dispatch with a generic payload type

`timescale 1ns/1ns

module fetch_queue #(
  parameter int  FETCH_DEPTH = 4,      // entries, power of two, at least 2
  parameter type payload_t   = logic   // one stored entry
) (
  input  logic     clock,
  input  logic     reset,
  input  logic     push,        // write push_data at the tail
  input  payload_t push_data,
  input  logic     pop,         // drop the head entry
  output logic     full,        // FETCH_DEPTH entries held
  output logic     head_valid,  // head_data holds a real entry
  output payload_t head_data
);

  ////////////////////
  // sizes
  ////////////////////

  localparam int ptr_w = $clog2(FETCH_DEPTH);  // pointers wrap on their own
  localparam int cnt_w = ptr_w + 1;            // count reaches FETCH_DEPTH
  localparam logic [cnt_w-1:0] depth_cnt = cnt_w'(FETCH_DEPTH);

  ////////////////////
  // storage
  ////////////////////

  payload_t          entries [FETCH_DEPTH];  // packet storage, no reset
  logic [ptr_w-1:0]  wr_ptr;                 // next free slot
  logic [ptr_w-1:0]  rd_ptr;                 // oldest entry
  logic [cnt_w-1:0]  count;                  // occupancy

  logic push_ok;  // push with room left
  logic pop_ok;   // pop with something to pop

  assign full       = (count == depth_cnt);
  assign head_valid = (count != '0);
  assign head_data  = entries[rd_ptr];  // visible the cycle after the push

  // guard both sides so a stray strobe cannot corrupt the count
  assign push_ok = push & ~full;
  assign pop_ok  = pop & head_valid;

  ////////////////////
  // write side
  ////////////////////

  always_ff @(posedge clock) begin
    if (push_ok) begin
      entries[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
    end else if (push_ok) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  ////////////////////
  // read side
  ////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_ptr <= '0;
    end else if (pop_ok) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // occupancy
  // a push and a pop on one edge leave it unchanged
  always_ff @(posedge clock) begin
    if (reset) begin
      count <= '0;
    end else begin
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== fetch_unit.f ====
fetch_pkg.sv
pc_ctrl_if.sv
fetch_control.sv
pc_unit.sv
fetch_queue.sv
fetch_unit.sv
tb_clock_gen.sv
imem_model.sv
fetch_unit_tb.sv

// ==== fetch_unit.sv ====
// instruction fetch top level tying control, pc datapath and packet queue together

`timescale 1ns/1ns

module fetch_unit #(
  parameter fetch_pkg::addr_t RESET_PC    = '0,  // first fetched pc
  parameter int               FETCH_DEPTH = 4    // queue entries, power of two
) (
  input  logic                          clock,
  input  logic                          reset,
  // retire side
  input  logic                          ret_valid_inst,    // one instruction retired
  input  logic                          ret_take_branch,   // it was a taken branch
  input  logic                          ret_branch_valid,  // it really is a branch
  input  fetch_pkg::addr_t              ret_target_pc,     // where to go on redirect
  // instruction memory side
  output fetch_pkg::addr_t              imem_addr,         // 8 byte aligned
  input  logic [fetch_pkg::line_w-1:0]  imem_data,         // same-cycle answer
  input  logic                          imem_valid,        // answer usable
  // dispatch side
  input  logic                          dispatch_en,       // dispatch takes the head
  output logic                          dispatch_valid,    // head packet is real
  output fetch_pkg::addr_t              dispatch_npc,      // head pc + 4
  output fetch_pkg::inst_t              dispatch_instruction
);
  import fetch_pkg::*;

  ////////////////////
  // internal wiring
  ////////////////////

  pc_ctrl_if pc_if ();  // control to pc datapath

  logic          push;          // packet written this edge
  logic          pop;           // head dropped this edge
  logic          queue_full;
  fetch_packet_t fetch_packet;  // built from pc and memory line
  fetch_packet_t head_packet;   // oldest queued packet

  ////////////////////
  // blocks
  ////////////////////

  fetch_control u_control (
    .clock            (clock),
    .reset            (reset),
    .ret_valid_inst   (ret_valid_inst),
    .ret_take_branch  (ret_take_branch),
    .ret_branch_valid (ret_branch_valid),
    .ret_target_pc    (ret_target_pc),
    .imem_valid       (imem_valid),
    .queue_full       (queue_full),
    .pc               (pc_if.control),
    .push             (push)
  );

  pc_unit #(
    .RESET_PC (RESET_PC)
  ) u_pc (
    .clock     (clock),
    .reset     (reset),
    .pc        (pc_if.datapath),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .packet    (fetch_packet)
  );

  fetch_queue #(
    .FETCH_DEPTH (FETCH_DEPTH),
    .payload_t   (fetch_packet_t)
  ) u_queue (
    .clock      (clock),
    .reset      (reset),
    .push       (push),
    .push_data  (fetch_packet),
    .pop        (pop),
    .full       (queue_full),
    .head_valid (dispatch_valid),
    .head_data  (head_packet)
  );

  ////////////////////
  // dispatch outputs
  ////////////////////

  assign pop = dispatch_en & dispatch_valid;  // only a real head is popped

  assign dispatch_npc         = head_packet.npc;
  assign dispatch_instruction = head_packet.inst;

endmodule

// ==== fetch_unit_tb.sv ====
// testbench that runs directed fetch unit tasks against a reference pc model

`timescale 1ns/1ns

module fetch_unit_tb;
  import fetch_pkg::*;

  localparam addr_t RESET_PC    = 64'h100;
  localparam int    FETCH_DEPTH = 4;
  localparam int    TIMEOUT     = 200;  // cycles allowed per wait

  logic               clock;
  logic               reset;
  logic               ret_valid_inst;
  logic               ret_take_branch;
  logic               ret_branch_valid;
  addr_t              ret_target_pc;
  addr_t              imem_addr;
  logic [line_w-1:0]  imem_data;
  logic               imem_valid;
  logic               stall_mode;  // memory stalls on or off
  logic               dispatch_en;
  logic               dispatch_valid;
  addr_t              dispatch_npc;
  inst_t              dispatch_instruction;

  addr_t ref_pc;          // pc of the next expected packet
  int    checks     = 0;
  int    mismatches = 0;
  int    timeouts   = 0;

  tb_clock_gen u_clock (.clock(clock), .reset(reset));

  imem_model u_imem (
    .clock      (clock),
    .reset      (reset),
    .stall_mode (stall_mode),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .imem_valid (imem_valid)
  );

  fetch_unit #(.RESET_PC(RESET_PC), .FETCH_DEPTH(FETCH_DEPTH)) DUT (.*);

  ////////////////////
  // helpers
  ////////////////////

  function automatic inst_t expected_inst(input addr_t a);
    return a[31:0] ^ 32'h1300_0000;  // memory content rule
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (actual !== expected) begin
      mismatches++;
      $display("FAILED %s expected %h actual %h at %0t", name, expected, actual, $time);
    end
  endtask

  // one retire strobe that also moves the model on a taken valid branch
  task automatic retire_pulse(input logic take, input logic branch_valid, input addr_t target);
    @(posedge clock);
    ret_valid_inst   <= 1'b1;
    ret_take_branch  <= take;
    ret_branch_valid <= branch_valid;
    ret_target_pc    <= target;
    @(posedge clock);
    ret_valid_inst   <= 1'b0;
    ret_take_branch  <= 1'b0;
    ret_branch_valid <= 1'b0;
    if (take && branch_valid) ref_pc = target;
  endtask

  // wait for a head packet, compare it with the model, then pop it
  task automatic pop_and_compare();
    int waited;
    waited = 0;
    @(negedge clock);
    while (!dispatch_valid && waited < TIMEOUT) begin
      @(negedge clock);
      waited++;
    end
    if (!dispatch_valid) begin
      timeouts++;
      $display("no packet reached dispatch within %0d cycles, pc %h", TIMEOUT, ref_pc);
    end else begin
      check_value("dispatch_npc", ref_pc + addr_t'(4), dispatch_npc);
      check_value("dispatch_instruction", 64'(expected_inst(ref_pc)),
                  64'(dispatch_instruction));
      ref_pc = ref_pc + addr_t'(4);
      @(posedge clock);
      dispatch_en <= 1'b1;
      @(posedge clock);  // pop edge
      dispatch_en <= 1'b0;
    end
  endtask

  task automatic expect_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clock);
      check_value("dispatch_valid", 64'd0, 64'(dispatch_valid));
    end
  endtask

  // line address is never misaligned
  always @(negedge clock) begin
    if (!reset) check_value("imem_addr[2:0]", 64'd0, 64'(imem_addr[2:0]));
  end

  ////////////////////
  // directed tests
  ////////////////////

  task automatic first_packet_after_reset();
    int waited;
    waited = 0;
    @(negedge clock);
    while (reset && waited < TIMEOUT) begin
      check_value("dispatch_valid", 64'd0, 64'(dispatch_valid));
      @(negedge clock);
      waited++;
    end
    if (reset) begin
      timeouts++;
      $display("reset still high after %0d cycles", TIMEOUT);
    end
    pop_and_compare();  // ready is set out of reset so no retire is needed
  endtask

  task automatic sequential_fetch();
    repeat (8) begin
      retire_pulse(1'b0, 1'b0, '0);
      pop_and_compare();  // halves alternate through the model pc
    end
  endtask

  task automatic single_instruction_mode();
    retire_pulse(1'b0, 1'b0, '0);
    pop_and_compare();
    expect_idle(20);  // no retire and no second packet
    retire_pulse(1'b0, 1'b0, '0);
    pop_and_compare();
  endtask

  task automatic branch_redirect();
    retire_pulse(1'b1, 1'b1, 64'h2000_0004);  // upper half target
    pop_and_compare();
    retire_pulse(1'b1, 1'b0, 64'h0000_5000);  // branch_valid low keeps fetch sequential
    pop_and_compare();
    retire_pulse(1'b0, 1'b1, 64'h0000_6000);  // valid branch that was not taken
    pop_and_compare();
    // plain retire and then a taken branch on the very next edge
    // ready is already set when the redirect arrives
    @(posedge clock);
    ret_valid_inst   <= 1'b1;
    @(posedge clock);
    ret_take_branch  <= 1'b1;
    ret_branch_valid <= 1'b1;
    ret_target_pc    <= 64'h0000_7000;
    @(posedge clock);
    ret_valid_inst   <= 1'b0;
    ret_take_branch  <= 1'b0;
    ret_branch_valid <= 1'b0;
    ref_pc = 64'h0000_7000;
    pop_and_compare();  // only the target packet is queued
  endtask

  task automatic queue_back_pressure();
    int i;
    for (i = 0; i < FETCH_DEPTH + 2; i++) begin
      retire_pulse(1'b0, 1'b0, '0);
      repeat (3) @(posedge clock);  // fetch lands one edge after the retire
      @(negedge clock);
      check_value("dispatch_valid", 64'd1, 64'(dispatch_valid));
    end
    // the extra retires only leave ready set for one more packet after a pop
    for (i = 0; i < FETCH_DEPTH + 1; i++) begin
      pop_and_compare();
    end
    expect_idle(10);
  endtask

  task automatic memory_stall_sequence();
    int i;
    @(posedge clock);
    stall_mode <= 1'b1;
    for (i = 0; i < 10; i++) begin
      if (i == 5) retire_pulse(1'b1, 1'b1, 64'h3004);
      else retire_pulse(1'b0, 1'b0, '0);
      pop_and_compare();
    end
    @(posedge clock);
    stall_mode <= 1'b0;
  endtask

  initial begin
    ret_valid_inst   = 1'b0;
    ret_take_branch  = 1'b0;
    ret_branch_valid = 1'b0;
    ret_target_pc    = '0;
    dispatch_en      = 1'b0;
    stall_mode       = 1'b0;
    ref_pc           = RESET_PC;
    first_packet_after_reset();
    sequential_fetch();
    single_instruction_mode();
    branch_redirect();
    queue_back_pressure();
    memory_stall_sequence();
    $display("checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== imem_model.sv ====
// testbench instruction memory answering each line address by a fixed rule

`timescale 1ns/1ns

module imem_model (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          stall_mode,  // random imem_valid when set
  input  fetch_pkg::addr_t              imem_addr,   // line address from the DUT
  output logic [fetch_pkg::line_w-1:0]  imem_data,
  output logic                          imem_valid
);
  import fetch_pkg::*;

  integer seed = 84;          // fixed seed for the stall pattern
  integer rnd;
  logic   stall_valid = 1'b1; // random valid level, used in stall mode only

  // instruction word stored at byte address a
  function automatic inst_t word_at(input addr_t a);
    return a[inst_w-1:0] ^ 32'h1300_0000;
  endfunction

  // low half holds the aligned word, high half the word after it
  assign imem_data = {word_at(imem_addr + addr_t'(4)), word_at(imem_addr)};

  // new random level each edge, valid about three times in four
  always @(posedge clock) begin
    if (reset) begin
      stall_valid <= 1'b1;
    end else begin
      rnd = $random(seed);
      stall_valid <= (rnd[1:0] != 2'b00);
    end
  end

  assign imem_valid = ~stall_mode | stall_valid;

endmodule

// ==== pc_ctrl_if.sv ====
// pc control interface between the fetch FSM and the pc datapath

`timescale 1ns/1ns

interface pc_ctrl_if;
  import fetch_pkg::*;

  logic  advance;    // level in the cycle of a fetch, step pc by 4
  logic  redirect;   // level for a taken retired branch
  addr_t target_pc;  // branch target, used only with redirect
  addr_t fetch_pc;   // pc currently being fetched

  // fetch control side
  modport control (
    output advance,
    output redirect,
    output target_pc,
    input  fetch_pc
  );

  // pc register side
  modport datapath (
    input  advance,
    input  redirect,
    input  target_pc,
    output fetch_pc
  );

endinterface

// ==== pc_unit.sv ====
// pc datapath with the pc register, next-pc mux, aligned address and half select

`timescale 1ns/1ns

module pc_unit #(
  parameter fetch_pkg::addr_t RESET_PC = '0  // pc loaded by reset
) (
  input  logic                          clock,
  input  logic                          reset,
  pc_ctrl_if.datapath                   pc,
  output fetch_pkg::addr_t              imem_addr,  // line address, bits 2:0 zero
  input  logic [fetch_pkg::line_w-1:0]  imem_data,  // line answered by the memory
  output fetch_pkg::fetch_packet_t      packet      // packet for the queue
);
  import fetch_pkg::*;

  addr_t pc_plus_4;  // sequential successor
  addr_t next_pc;    // value loaded when the pc is enabled
  logic  pc_enable;
  inst_t inst;       // instruction from the selected half

  ////////////////////
  // next pc
  ////////////////////

  assign pc_plus_4 = pc.fetch_pc + addr_t'(4);

  // redirect beats the sequential step
  assign next_pc   = pc.redirect ? pc.target_pc : pc_plus_4;
  assign pc_enable = pc.redirect | pc.advance;  // otherwise the pc holds

  // pc register, its value is fetch_pc on the interface
  always_ff @(posedge clock) begin
    if (reset) begin
      pc.fetch_pc <= RESET_PC;
    end else if (pc_enable) begin
      pc.fetch_pc <= next_pc;
    end
  end

  ////////////////////
  // memory side
  ////////////////////

  // memory is one line wide so drop the byte offset
  assign imem_addr = {pc.fetch_pc[addr_w-1:3], 3'b000};

  // pc bit 2 picks the upper or lower instruction of the line
  assign inst = pc.fetch_pc[2] ? imem_data[2*inst_w-1:inst_w]
                               : imem_data[inst_w-1:0];

  assign packet.npc  = pc_plus_4;  // npc travels with the instruction
  assign packet.inst = inst;

endmodule

// ==== tb_clock_gen.sv ====
// testbench clock and reset source, 100 ns period with reset over the first cycles

`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 50,  // ns
  parameter int RESET_CYCLES = 10
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #HALF_PERIOD clock = ~clock;
  end

  // synchronous reset, dropped right on an edge
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;
  end

endmodule
